// File: compile.f
src/csr_pkg.sv
src/csr_access_ctrl.sv
src/csr_trap_regs.sv
src/csr_counter_bank.sv
src/csr_read_select.sv
src/csr_unit.sv
tb/tb_csr_unit.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the csr unit testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_csr_unit \
    -Mdir obj_dir -o sim_csr_unit \
    -f compile.f

./obj_dir/sim_csr_unit | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "simulation reported errors, see sim.log"
    exit 1
fi

echo "simulation finished without errors"

// File: src/csr_access_ctrl.sv
// csr access handshake
`timescale 1ns/1ps
`default_nettype none

module csr_access_ctrl
    import csr_pkg::*;
(
    input  wire       i_clk,
    input  wire       i_rst_n,
    input  wire       i_req,
    input  csr_addr_t i_csr_addr,
    input  csr_op_e   i_op,
    input  csr_data_t i_rs1,
    input  csr_data_t i_imm,
    input  csr_data_t i_cur_data,
    output logic      o_ack,
    output csr_data_t o_rdata,
    output logic      o_wr_en,
    output csr_addr_t o_wr_addr,
    output csr_data_t o_wr_data
);

    typedef enum logic {
        ST_IDLE,
        ST_HOLD
    } state_t;

    state_t    state;
    csr_data_t operand;
    csr_data_t new_val;
    logic      op_write;

    // read-modify-write value
    always_comb begin
        // immediate forms have bit 2 set
        operand  = i_op[2] ? i_imm : i_rs1;
        new_val  = i_cur_data;
        op_write = 1'b0;
        case (i_op)
            CSR_OP_RW, CSR_OP_RWI: begin
                new_val  = operand;
                op_write = 1'b1;
            end
            CSR_OP_RS, CSR_OP_RSI: begin
                new_val  = i_cur_data | operand;
                // zero mask leaves the csr untouched, so skip the write
                op_write = |operand;
            end
            CSR_OP_RC, CSR_OP_RCI: begin
                new_val  = i_cur_data & ~operand;
                op_write = |operand;
            end
            default: begin
                op_write = 1'b0;
            end
        endcase
    end

    // strobe only on the accepting edge
    assign o_wr_en   = (state == ST_IDLE) && i_req && op_write;
    assign o_wr_addr = i_csr_addr;
    assign o_wr_data = new_val;
    assign o_ack     = (state == ST_HOLD);

    // four phase req/ack
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state   <= ST_IDLE;
            o_rdata <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_req) begin
                        // old value, same edge as the write
                        o_rdata <= i_cur_data;
                        state   <= ST_HOLD;
                    end
                end
                ST_HOLD: begin
                    // wait for requester to drop req
                    if (!i_req) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/csr_counter_bank.sv
// machine counters
`timescale 1ns/1ps
`default_nettype none

module csr_counter_bank
    import csr_pkg::*;
(
    input  wire         i_clk,
    input  wire         i_rst_n,
    input  wire         i_wr_en,
    input  csr_addr_t   i_wr_addr,
    input  csr_data_t   i_wr_data,
    input  wire         i_retire,
    output logic [63:0] o_mcycle,
    output logic [63:0] o_minstret,
    output logic        o_inhibit_cy,
    output logic        o_inhibit_ir
);

    logic wr_cycle_lo;
    logic wr_cycle_hi;
    logic wr_instret_lo;
    logic wr_instret_hi;
    logic wr_inhibit;

    assign wr_cycle_lo   = i_wr_en && (i_wr_addr == CSR_MCYCLE);
    assign wr_cycle_hi   = i_wr_en && (i_wr_addr == CSR_MCYCLEH);
    assign wr_instret_lo = i_wr_en && (i_wr_addr == CSR_MINSTRET);
    assign wr_instret_hi = i_wr_en && (i_wr_addr == CSR_MINSTRETH);
    assign wr_inhibit    = i_wr_en && (i_wr_addr == CSR_MCOUNTINHIBIT);

    // half writes win over the count
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_mcycle   <= '0;
            o_minstret <= '0;
        end else begin
            if (wr_cycle_lo) begin
                o_mcycle[31:0] <= i_wr_data;
            end else if (wr_cycle_hi) begin
                o_mcycle[63:32] <= i_wr_data;
            end else if (!o_inhibit_cy) begin
                o_mcycle <= o_mcycle + 64'd1;
            end

            // one step per retire pulse
            if (wr_instret_lo) begin
                o_minstret[31:0] <= i_wr_data;
            end else if (wr_instret_hi) begin
                o_minstret[63:32] <= i_wr_data;
            end else if (i_retire && !o_inhibit_ir) begin
                o_minstret <= o_minstret + 64'd1;
            end
        end
    end

    // inhibit bits, counters run after reset
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_inhibit_cy <= 1'b0;
            o_inhibit_ir <= 1'b0;
        end else if (wr_inhibit) begin
            o_inhibit_cy <= i_wr_data[INHIBIT_CY_BIT];
            o_inhibit_ir <= i_wr_data[INHIBIT_IR_BIT];
        end
    end

endmodule

`default_nettype wire

// File: src/csr_pkg.sv
// machine mode csr definitions
`default_nettype none

package csr_pkg;

    // data path and address widths
    localparam int XLEN = 32;

    typedef logic [11:0]     csr_addr_t;
    typedef logic [XLEN-1:0] csr_data_t;

    // funct3 codes of the system instructions
    // bit 2 picks the immediate operand
    typedef enum logic [2:0] {
        CSR_OP_RW  = 3'b001,
        CSR_OP_RS  = 3'b010,
        CSR_OP_RC  = 3'b011,
        CSR_OP_RWI = 3'b101,
        CSR_OP_RSI = 3'b110,
        CSR_OP_RCI = 3'b111
    } csr_op_e;

    // machine information
    localparam csr_addr_t CSR_MVENDORID     = 12'hF11;
    localparam csr_addr_t CSR_MARCHID       = 12'hF12;
    localparam csr_addr_t CSR_MIMPID        = 12'hF13;
    localparam csr_addr_t CSR_MHARTID       = 12'hF14;
    // trap setup
    localparam csr_addr_t CSR_MSTATUS       = 12'h300;
    localparam csr_addr_t CSR_MISA          = 12'h301;
    localparam csr_addr_t CSR_MIE           = 12'h304;
    localparam csr_addr_t CSR_MTVEC         = 12'h305;
    localparam csr_addr_t CSR_MCOUNTINHIBIT = 12'h320;
    // trap handling
    localparam csr_addr_t CSR_MSCRATCH      = 12'h340;
    localparam csr_addr_t CSR_MEPC          = 12'h341;
    localparam csr_addr_t CSR_MCAUSE        = 12'h342;
    localparam csr_addr_t CSR_MTVAL         = 12'h343;
    localparam csr_addr_t CSR_MIP           = 12'h344;
    // counters, upper halves for rv32
    localparam csr_addr_t CSR_MCYCLE        = 12'hB00;
    localparam csr_addr_t CSR_MINSTRET      = 12'hB02;
    localparam csr_addr_t CSR_MCYCLEH       = 12'hB80;
    localparam csr_addr_t CSR_MINSTRETH     = 12'hB82;

    // mxl = 1 (32 bit), extension I
    localparam csr_data_t MISA_VALUE = 32'h4000_0100;

    // mstatus fields
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;

    // mie enable bits
    localparam int MIE_MSIE_BIT = 3;
    localparam int MIE_MTIE_BIT = 7;
    localparam int MIE_MEIE_BIT = 11;

    // mcause layout
    localparam int MCAUSE_INT_BIT = 31;
    localparam int MCAUSE_CODE_W  = 4;

    // mcountinhibit bits
    localparam int INHIBIT_CY_BIT = 0;
    localparam int INHIBIT_IR_BIT = 2;

endpackage

`default_nettype wire

// File: src/csr_read_select.sv
// csr read mux
`timescale 1ns/1ps
`default_nettype none

module csr_read_select
    import csr_pkg::*;
(
    input  csr_addr_t                i_csr_addr,
    input  wire                      i_mstatus_mie,
    input  wire                      i_mstatus_mpie,
    input  wire [2:0]                i_mie_bits,
    input  csr_data_t                i_mtvec,
    input  csr_data_t                i_mscratch,
    input  csr_data_t                i_mepc,
    input  wire                      i_mcause_int,
    input  wire [MCAUSE_CODE_W-1:0]  i_mcause_code,
    input  csr_data_t                i_mtval,
    input  wire [63:0]               i_mcycle,
    input  wire [63:0]               i_minstret,
    input  wire                      i_inhibit_cy,
    input  wire                      i_inhibit_ir,
    output csr_data_t                o_data
);

    always_comb begin
        // unimplemented bits read zero
        o_data = '0;
        case (i_csr_addr)
            CSR_MSTATUS: begin
                o_data[MSTATUS_MIE_BIT]           = i_mstatus_mie;
                o_data[MSTATUS_MPIE_BIT]          = i_mstatus_mpie;
                // only machine mode exists
                o_data[MSTATUS_MPP_LSB +: 2]      = 2'b11;
            end
            CSR_MISA:     o_data = MISA_VALUE;
            CSR_MIE: begin
                o_data[MIE_MSIE_BIT] = i_mie_bits[0];
                o_data[MIE_MTIE_BIT] = i_mie_bits[1];
                o_data[MIE_MEIE_BIT] = i_mie_bits[2];
            end
            CSR_MTVEC:    o_data = i_mtvec;
            CSR_MSCRATCH: o_data = i_mscratch;
            CSR_MEPC:     o_data = i_mepc;
            CSR_MCAUSE: begin
                o_data[MCAUSE_INT_BIT]        = i_mcause_int;
                o_data[MCAUSE_CODE_W-1:0]     = i_mcause_code;
            end
            CSR_MTVAL:    o_data = i_mtval;
            // counter halves
            CSR_MCYCLE:    o_data = i_mcycle[31:0];
            CSR_MCYCLEH:   o_data = i_mcycle[63:32];
            CSR_MINSTRET:  o_data = i_minstret[31:0];
            CSR_MINSTRETH: o_data = i_minstret[63:32];
            CSR_MCOUNTINHIBIT: begin
                o_data[INHIBIT_CY_BIT] = i_inhibit_cy;
                o_data[INHIBIT_IR_BIT] = i_inhibit_ir;
            end
            // id regs and mip are hardwired zero
            CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID, CSR_MIP: begin
                o_data = '0;
            end
            default: begin
                o_data = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/csr_trap_regs.sv
// trap setup and handling registers
`timescale 1ns/1ps
`default_nettype none

module csr_trap_regs
    import csr_pkg::*;
#(
    parameter csr_data_t TRAP_ADDRESS = '0
) (
    input  wire                     i_clk,
    input  wire                     i_rst_n,
    input  wire                     i_wr_en,
    input  csr_addr_t               i_wr_addr,
    input  csr_data_t               i_wr_data,
    input  wire                     i_trap,
    input  csr_data_t               i_trap_pc,
    input  wire                     i_trap_cause_int,
    input  wire [MCAUSE_CODE_W-1:0] i_trap_cause_code,
    input  csr_data_t               i_trap_tval,
    input  wire                     i_mret,
    output logic                    o_mstatus_mie,
    output logic                    o_mstatus_mpie,
    output logic [2:0]              o_mie_bits,
    output csr_data_t               o_mtvec,
    output csr_data_t               o_mscratch,
    output csr_data_t               o_mepc,
    output logic                    o_mcause_int,
    output logic [MCAUSE_CODE_W-1:0] o_mcause_code,
    output csr_data_t               o_mtval,
    output csr_data_t               o_trap_target
);

    logic      wr_mstatus;
    logic      wr_mie;
    logic      wr_mtvec;
    logic      wr_mscratch;
    logic      wr_mepc;
    logic      wr_mcause;
    logic      wr_mtval;
    csr_data_t tvec_base;

    // own address decode
    assign wr_mstatus  = i_wr_en && (i_wr_addr == CSR_MSTATUS);
    assign wr_mie      = i_wr_en && (i_wr_addr == CSR_MIE);
    assign wr_mtvec    = i_wr_en && (i_wr_addr == CSR_MTVEC);
    assign wr_mscratch = i_wr_en && (i_wr_addr == CSR_MSCRATCH);
    assign wr_mepc     = i_wr_en && (i_wr_addr == CSR_MEPC);
    assign wr_mcause   = i_wr_en && (i_wr_addr == CSR_MCAUSE);
    assign wr_mtval    = i_wr_en && (i_wr_addr == CSR_MTVAL);

    // mstatus enables, csr write beats trap and mret
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_mstatus_mie  <= 1'b0;
            o_mstatus_mpie <= 1'b0;
        end else if (wr_mstatus) begin
            o_mstatus_mie  <= i_wr_data[MSTATUS_MIE_BIT];
            o_mstatus_mpie <= i_wr_data[MSTATUS_MPIE_BIT];
        end else if (i_trap) begin
            // stack mie, no nesting in the handler
            o_mstatus_mpie <= o_mstatus_mie;
            o_mstatus_mie  <= 1'b0;
        end else if (i_mret) begin
            o_mstatus_mie  <= o_mstatus_mpie;
            o_mstatus_mpie <= 1'b1;
        end
    end

    // setup regs, only written by software
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_mie_bits <= '0;
            o_mtvec    <= TRAP_ADDRESS;
            o_mscratch <= '0;
        end else begin
            // meie, mtie, msie
            if (wr_mie) begin
                o_mie_bits <= {i_wr_data[MIE_MEIE_BIT],
                               i_wr_data[MIE_MTIE_BIT],
                               i_wr_data[MIE_MSIE_BIT]};
            end
            if (wr_mtvec) begin
                o_mtvec <= i_wr_data;
            end
            if (wr_mscratch) begin
                o_mscratch <= i_wr_data;
            end
        end
    end

    // trap state, trap entry beats software
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_mepc        <= '0;
            o_mcause_int  <= 1'b0;
            o_mcause_code <= '0;
            o_mtval       <= '0;
        end else if (i_trap) begin
            o_mepc        <= {i_trap_pc[XLEN-1:2], 2'b00};
            o_mcause_int  <= i_trap_cause_int;
            o_mcause_code <= i_trap_cause_code;
            o_mtval       <= i_trap_tval;
        end else begin
            // pc stays word aligned
            if (wr_mepc) begin
                o_mepc <= {i_wr_data[XLEN-1:2], 2'b00};
            end
            if (wr_mcause) begin
                o_mcause_int  <= i_wr_data[MCAUSE_INT_BIT];
                o_mcause_code <= i_wr_data[MCAUSE_CODE_W-1:0];
            end
            if (wr_mtval) begin
                o_mtval <= i_wr_data;
            end
        end
    end

    // mode 01 vectors interrupts to base + 4 * code
    assign tvec_base = {o_mtvec[XLEN-1:2], 2'b00};

    always_comb begin
        o_trap_target = tvec_base;
        if ((o_mtvec[1:0] == 2'b01) && o_mcause_int) begin
            o_trap_target = tvec_base + XLEN'({o_mcause_code, 2'b00});
        end
    end

endmodule

`default_nettype wire

// File: src/csr_unit.sv
// machine mode csr unit
`timescale 1ns/1ps
`default_nettype none

module csr_unit
    import csr_pkg::*;
#(
    parameter csr_data_t TRAP_ADDRESS = '0
) (
    input  wire                     i_clk,
    input  wire                     i_rst_n,
    // requester side
    input  wire                     i_req,
    input  csr_addr_t               i_csr_addr,
    input  csr_op_e                 i_op,
    input  csr_data_t               i_rs1,
    input  csr_data_t               i_imm,
    output logic                    o_ack,
    output csr_data_t               o_rdata,
    // pipeline pulses
    input  wire                     i_trap,
    input  csr_data_t               i_trap_pc,
    input  wire                     i_trap_cause_int,
    input  wire [MCAUSE_CODE_W-1:0] i_trap_cause_code,
    input  csr_data_t               i_trap_tval,
    input  wire                     i_mret,
    input  wire                     i_retire,
    output csr_data_t               o_trap_target,
    output csr_data_t               o_epc
);

    logic                     wr_en;
    csr_addr_t                wr_addr;
    csr_data_t                wr_data;
    csr_data_t                cur_data;
    logic                     mstatus_mie;
    logic                     mstatus_mpie;
    logic [2:0]               mie_bits;
    csr_data_t                mtvec;
    csr_data_t                mscratch;
    csr_data_t                mepc;
    logic                     mcause_int;
    logic [MCAUSE_CODE_W-1:0] mcause_code;
    csr_data_t                mtval;
    logic [63:0]              mcycle;
    logic [63:0]              minstret;
    logic                     inhibit_cy;
    logic                     inhibit_ir;

    // handshake and new value
    csr_access_ctrl u_access_ctrl (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_req      (i_req),
        .i_csr_addr (i_csr_addr),
        .i_op       (i_op),
        .i_rs1      (i_rs1),
        .i_imm      (i_imm),
        .i_cur_data (cur_data),
        .o_ack      (o_ack),
        .o_rdata    (o_rdata),
        .o_wr_en    (wr_en),
        .o_wr_addr  (wr_addr),
        .o_wr_data  (wr_data)
    );

    csr_trap_regs #(
        .TRAP_ADDRESS (TRAP_ADDRESS)
    ) u_trap_regs (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_wr_en           (wr_en),
        .i_wr_addr         (wr_addr),
        .i_wr_data         (wr_data),
        .i_trap            (i_trap),
        .i_trap_pc         (i_trap_pc),
        .i_trap_cause_int  (i_trap_cause_int),
        .i_trap_cause_code (i_trap_cause_code),
        .i_trap_tval       (i_trap_tval),
        .i_mret            (i_mret),
        .o_mstatus_mie     (mstatus_mie),
        .o_mstatus_mpie    (mstatus_mpie),
        .o_mie_bits        (mie_bits),
        .o_mtvec           (mtvec),
        .o_mscratch        (mscratch),
        .o_mepc            (mepc),
        .o_mcause_int      (mcause_int),
        .o_mcause_code     (mcause_code),
        .o_mtval           (mtval),
        .o_trap_target     (o_trap_target)
    );

    csr_counter_bank u_counter_bank (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_wr_en      (wr_en),
        .i_wr_addr    (wr_addr),
        .i_wr_data    (wr_data),
        .i_retire     (i_retire),
        .o_mcycle     (mcycle),
        .o_minstret   (minstret),
        .o_inhibit_cy (inhibit_cy),
        .o_inhibit_ir (inhibit_ir)
    );

    // current value for the addressed csr
    csr_read_select u_read_select (
        .i_csr_addr     (i_csr_addr),
        .i_mstatus_mie  (mstatus_mie),
        .i_mstatus_mpie (mstatus_mpie),
        .i_mie_bits     (mie_bits),
        .i_mtvec        (mtvec),
        .i_mscratch     (mscratch),
        .i_mepc         (mepc),
        .i_mcause_int   (mcause_int),
        .i_mcause_code  (mcause_code),
        .i_mtval        (mtval),
        .i_mcycle       (mcycle),
        .i_minstret     (minstret),
        .i_inhibit_cy   (inhibit_cy),
        .i_inhibit_ir   (inhibit_ir),
        .o_data         (cur_data)
    );

    // return address for mret
    assign o_epc = mepc;

endmodule

`default_nettype wire

// File: tb/tb_csr_unit.sv
// csr unit testbench
`timescale 1ns/1ps
`default_nettype none

module tb_csr_unit;
    import csr_pkg::*;

    localparam csr_data_t TRAP_ADDR  = 32'h0000_0100;
    localparam int        WAIT_LIMIT = 50;

    logic                     clk;
    logic                     rst_n;
    logic                     req;
    csr_addr_t                csr_addr;
    csr_op_e                  op;
    csr_data_t                rs1;
    csr_data_t                imm;
    logic                     ack;
    csr_data_t                rdata;
    logic                     trap;
    csr_data_t                trap_pc;
    logic                     trap_cause_int;
    logic [MCAUSE_CODE_W-1:0] trap_cause_code;
    csr_data_t                trap_tval;
    logic                     mret;
    logic                     retire;
    csr_data_t                trap_target;
    csr_data_t                epc;

    int          value_errors;
    int          timeout_errors;
    logic [31:0] rng_state;

    csr_unit #(
        .TRAP_ADDRESS (TRAP_ADDR)
    ) dut (
        .i_clk             (clk),
        .i_rst_n           (rst_n),
        .i_req             (req),
        .i_csr_addr        (csr_addr),
        .i_op              (op),
        .i_rs1             (rs1),
        .i_imm             (imm),
        .o_ack             (ack),
        .o_rdata           (rdata),
        .i_trap            (trap),
        .i_trap_pc         (trap_pc),
        .i_trap_cause_int  (trap_cause_int),
        .i_trap_cause_code (trap_cause_code),
        .i_trap_tval       (trap_tval),
        .i_mret            (mret),
        .i_retire          (retire),
        .o_trap_target     (trap_target),
        .o_epc             (epc)
    );

    // 20 ns period
    always #10 clk = ~clk;

    // xorshift32 step
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_value(input string name, input csr_data_t got,
                               input csr_data_t expected);
        assert (got === expected) else begin
            $display("** Error %s: got 0x%h, expected 0x%h", name, got, expected);
            value_errors++;
        end
    endtask

    // one four phase access that returns with the clock low
    task automatic csr_access(input csr_addr_t addr, input csr_op_e acc_op,
                              input csr_data_t acc_rs1, input csr_data_t acc_imm,
                              output csr_data_t old_val);
        int cycles;
        @(posedge clk);
        req      <= 1'b1;
        csr_addr <= addr;
        op       <= acc_op;
        rs1      <= acc_rs1;
        imm      <= acc_imm;
        cycles = 0;
        @(negedge clk);
        while (!ack && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (ack) else begin
            $display("timeout: no ack for access to csr 0x%h", addr);
            timeout_errors++;
        end
        old_val = rdata;
        @(posedge clk);
        req <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (ack && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (!ack) else begin
            $display("timeout: ack still high after req dropped, csr 0x%h", addr);
            timeout_errors++;
        end
    endtask

    // set with a zero mask reads without side effects
    task automatic read_csr(input csr_addr_t addr, output csr_data_t val);
        csr_access(addr, CSR_OP_RS, '0, '0, val);
    endtask

    task automatic write_csr(input csr_addr_t addr, input csr_data_t val);
        csr_data_t unused_old;
        csr_access(addr, CSR_OP_RW, val, '0, unused_old);
    endtask

    task automatic test_reset_values();
        csr_data_t d;
        // handshake outputs idle out of reset
        check_value("o_ack", 32'(ack), '0);
        check_value("o_rdata", rdata, '0);
        read_csr(CSR_MTVEC, d);
        check_value("mtvec", d, TRAP_ADDR);
        read_csr(CSR_MISA, d);
        check_value("misa", d, MISA_VALUE);
        // mpp is the only bit set
        read_csr(CSR_MSTATUS, d);
        check_value("mstatus", d, 32'h0000_1800);
        read_csr(CSR_MSCRATCH, d);
        check_value("mscratch", d, '0);
        read_csr(CSR_MVENDORID, d);
        check_value("mvendorid", d, '0);
        read_csr(CSR_MARCHID, d);
        check_value("marchid", d, '0);
        read_csr(CSR_MIMPID, d);
        check_value("mimpid", d, '0);
        read_csr(CSR_MHARTID, d);
        check_value("mhartid", d, '0);
        read_csr(CSR_MIP, d);
        check_value("mip", d, '0);
        // nothing lives at 0x7c0
        read_csr(12'h7C0, d);
        check_value("unknown csr", d, '0);
        check_value("o_trap_target", trap_target, TRAP_ADDR);
    endtask

    task automatic test_read_modify_write();
        csr_op_e   ops [6] = '{CSR_OP_RW, CSR_OP_RS, CSR_OP_RC,
                               CSR_OP_RWI, CSR_OP_RSI, CSR_OP_RCI};
        csr_data_t model;
        csr_data_t v_rs1;
        csr_data_t v_imm;
        csr_data_t operand;
        csr_data_t expected;
        csr_data_t d;
        model = '0;
        for (int i = 0; i < 6; i++) begin
            v_rs1 = next_random();
            v_imm = next_random();
            // immediate forms take imm
            operand = (i >= 3) ? v_imm : v_rs1;
            case (ops[i])
                CSR_OP_RW, CSR_OP_RWI: expected = operand;
                CSR_OP_RS, CSR_OP_RSI: expected = model | operand;
                default:               expected = model & ~operand;
            endcase
            csr_access(CSR_MSCRATCH, ops[i], v_rs1, v_imm, d);
            check_value("o_rdata mscratch", d, model);
            model = expected;
        end
        read_csr(CSR_MSCRATCH, d);
        check_value("mscratch", d, model);
        // mepc keeps word alignment
        v_rs1 = next_random();
        write_csr(CSR_MEPC, v_rs1);
        read_csr(CSR_MEPC, d);
        check_value("mepc", d, v_rs1 & 32'hFFFF_FFFC);
        // read only registers ignore writes
        write_csr(CSR_MISA, next_random());
        read_csr(CSR_MISA, d);
        check_value("misa", d, MISA_VALUE);
        write_csr(CSR_MVENDORID, next_random());
        read_csr(CSR_MVENDORID, d);
        check_value("mvendorid", d, '0);
    endtask

    task automatic test_masked_registers();
        csr_data_t d;
        write_csr(CSR_MSTATUS, '1);
        read_csr(CSR_MSTATUS, d);
        check_value("mstatus", d, 32'h0000_1888);
        write_csr(CSR_MIE, '1);
        read_csr(CSR_MIE, d);
        check_value("mie", d, 32'h0000_0888);
        write_csr(CSR_MCAUSE, '1);
        read_csr(CSR_MCAUSE, d);
        check_value("mcause", d, 32'h8000_000F);
    endtask

    task automatic test_trap_and_mret();
        csr_data_t                pc;
        csr_data_t                tval;
        csr_data_t                tmp;
        logic [MCAUSE_CODE_W-1:0] code;
        csr_data_t                d;
        // mie set and mpie clear
        write_csr(CSR_MSTATUS, 32'h0000_0008);
        pc   = next_random();
        tval = next_random();
        tmp  = next_random();
        code = tmp[MCAUSE_CODE_W-1:0];
        @(posedge clk);
        trap            <= 1'b1;
        trap_pc         <= pc;
        trap_cause_int  <= 1'b0;
        trap_cause_code <= code;
        trap_tval       <= tval;
        @(posedge clk);
        trap <= 1'b0;
        @(negedge clk);
        check_value("o_epc", epc, pc & 32'hFFFF_FFFC);
        read_csr(CSR_MEPC, d);
        check_value("mepc", d, pc & 32'hFFFF_FFFC);
        read_csr(CSR_MCAUSE, d);
        check_value("mcause", d, {28'h0, code});
        read_csr(CSR_MTVAL, d);
        check_value("mtval", d, tval);
        // mie stacked into mpie
        read_csr(CSR_MSTATUS, d);
        check_value("mstatus", d, 32'h0000_1880);
        @(posedge clk);
        mret <= 1'b1;
        @(posedge clk);
        mret <= 1'b0;
        read_csr(CSR_MSTATUS, d);
        check_value("mstatus", d, 32'h0000_1888);
    endtask

    task automatic test_trap_target();
        csr_data_t base;
        base = next_random() & 32'hFFFF_FF00;
        // an interrupt cause leaves the mode bits to decide
        write_csr(CSR_MCAUSE, 32'h8000_0007);
        write_csr(CSR_MTVEC, base);
        check_value("o_trap_target", trap_target, base);
        // vectored mode sends interrupt 7 to base + 28
        write_csr(CSR_MTVEC, base | 32'h1);
        check_value("o_trap_target", trap_target, base + 32'd28);
        // exceptions never vector
        write_csr(CSR_MCAUSE, 32'h0000_0007);
        check_value("o_trap_target", trap_target, base);
    endtask

    task automatic test_counters();
        csr_data_t   cyc_lo;
        csr_data_t   cyc_hi;
        csr_data_t   ins_lo;
        csr_data_t   ins_hi;
        csr_data_t   d;
        csr_data_t   first;
        logic [63:0] ins_expected;
        int          n;
        // freeze both counters
        write_csr(CSR_MCOUNTINHIBIT, 32'h0000_0005);
        // low cycle half kept small so later reads cannot wrap
        cyc_lo = next_random() & 32'h0FFF_FFFF;
        cyc_hi = next_random();
        ins_lo = next_random();
        ins_hi = next_random();
        write_csr(CSR_MCYCLE, cyc_lo);
        write_csr(CSR_MCYCLEH, cyc_hi);
        write_csr(CSR_MINSTRET, ins_lo);
        write_csr(CSR_MINSTRETH, ins_hi);
        read_csr(CSR_MCYCLE, d);
        check_value("mcycle", d, cyc_lo);
        read_csr(CSR_MCYCLEH, d);
        check_value("mcycleh", d, cyc_hi);
        read_csr(CSR_MINSTRET, d);
        check_value("minstret", d, ins_lo);
        read_csr(CSR_MINSTRETH, d);
        check_value("minstreth", d, ins_hi);
        // release instret only
        write_csr(CSR_MCOUNTINHIBIT, 32'h0000_0001);
        n = int'(next_random() & 32'd7) + 3;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            retire <= 1'b1;
            @(posedge clk);
            retire <= 1'b0;
        end
        ins_expected = {ins_hi, ins_lo} + 64'(n);
        read_csr(CSR_MINSTRET, d);
        check_value("minstret", d, ins_expected[31:0]);
        read_csr(CSR_MINSTRETH, d);
        check_value("minstreth", d, ins_expected[63:32]);
        // let mcycle run
        write_csr(CSR_MCOUNTINHIBIT, '0);
        read_csr(CSR_MCYCLE, first);
        read_csr(CSR_MCYCLE, d);
        assert (d > first) else begin
            $display("** Error mcycle: second read 0x%h, not above first 0x%h", d, first);
            value_errors++;
        end
    endtask

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        req             = 1'b0;
        csr_addr        = '0;
        op              = CSR_OP_RS;
        rs1             = '0;
        imm             = '0;
        trap            = 1'b0;
        trap_pc         = '0;
        trap_cause_int  = 1'b0;
        trap_cause_code = '0;
        trap_tval       = '0;
        mret            = 1'b0;
        retire          = 1'b0;
        value_errors    = 0;
        timeout_errors  = 0;
        rng_state       = 32'd83545;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        test_reset_values();
        test_read_modify_write();
        test_masked_registers();
        test_trap_and_mret();
        test_trap_target();
        test_counters();
        $display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
